/* bench/issue_core_tb.sv */
`timescale 1ns/10ps

module issue_core_tb
  import isa_pkg::*;
  import core_pkg::*;
();

  localparam int max_cycles   = 2000; // about ten times the summed test length
  localparam int settle_limit = 50;   // cycles allowed for the last results to arrive

  logic     clock;
  logic     reset;
  logic     dispatch_en;
  fu_kind_t dispatch_kind;
  func_t    dispatch_func;
  tag_t     dest_tag;
  tag_t     src1_tag;
  logic     src1_ready;
  tag_t     src2_tag;
  logic     src2_ready;
  logic     preload_en;
  tag_t     preload_tag;
  data_t    preload_value;
  logic     rs_hazard;
  logic     cdb_valid;
  tag_t     cdb_tag;
  data_t    cdb_value;

  // scoreboard by tag
  data_t       model_val [num_tags]; // value the tag holds or will hold
  logic        pending   [num_tags]; // result expected on the cdb
  int          bcast_at  [num_tags]; // cycle of the last broadcast
  int          cycle;
  int          accepted_at;          // edge that took the last dispatch
  logic [31:0] lcg_state;

  issue_core issue_core_inst (
    .clock, .reset, .dispatch_en, .dispatch_kind, .dispatch_func, .dest_tag,
    .src1_tag, .src1_ready, .src2_tag, .src2_ready, .preload_en, .preload_tag,
    .preload_value, .rs_hazard, .cdb_valid, .cdb_tag, .cdb_value
  );

  always #20 clock = ~clock; // 40 ns period

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("mismatch %s: actual 0x%h expected 0x%h", name, actual, expected));
    end
  endtask

  // expected result per function code
  function automatic data_t op_result(input func_t func, input data_t a, input data_t b);
    case (func)
      func_add: return a + b;
      func_sub: return a - b;
      func_and: return a & b;
      func_or:  return a | b;
      func_xor: return a ^ b;
      default:  return a * b; // mul keeps the low 32 bits
    endcase
  endfunction

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int pick(input int n);
    logic [31:0] r;
    r = next_random();
    return int'(r[31:16]) % n; // upper lcg bits, the low ones repeat quickly
  endfunction

  function automatic int pending_count();
    int n;
    n = 0;
    for (int t = 0; t < num_tags; t++) n += pending[t];
    return n;
  endfunction

  // cdb watcher and cycle counter
  always @(posedge clock) begin
    if (!reset && cdb_valid) begin
      if (!pending[cdb_tag]) begin
        fail_run($sformatf("tag %0d was broadcast with no result pending for it", cdb_tag));
      end
      check_value($sformatf("cdb_value tag %0d", cdb_tag), cdb_value, model_val[cdb_tag]);
      pending[cdb_tag]  = 1'b0;
      bcast_at[cdb_tag] = cycle;
    end
    cycle = cycle + 1;
    if (cycle >= max_cycles) fail_run("timeout, the tests did not finish in time");
  end

  task automatic preload_reg(input tag_t tag, input data_t value);
    @(negedge clock);
    dispatch_en   = 1'b0;
    preload_en    = 1'b1;
    preload_tag   = tag;
    preload_value = value;
    model_val[tag] = value;
    @(posedge clock);
  endtask

  // held while rs_hazard is high, ready bits follow the scoreboard
  task automatic dispatch_op(input fu_kind_t kind, input func_t func, input tag_t dest,
                             input tag_t s1, input tag_t s2);
    @(negedge clock);
    preload_en    = 1'b0;
    dispatch_en   = 1'b1;
    dispatch_kind = kind;
    dispatch_func = func;
    dest_tag      = dest;
    src1_tag      = s1;
    src2_tag      = s2;
    src1_ready    = !pending[s1];
    src2_ready    = !pending[s2];
    #1;
    while (rs_hazard) begin
      @(negedge clock);
      src1_ready = !pending[s1];
      src2_ready = !pending[s2];
      #1;
    end
    accepted_at     = cycle; // the coming edge samples this count
    model_val[dest] = op_result(func, model_val[s1], model_val[s2]);
    pending[dest]   = 1'b1;
    @(posedge clock);
  endtask

  task automatic drain();
    @(negedge clock);
    dispatch_en = 1'b0;
    preload_en  = 1'b0;
    while (pending_count() != 0) @(negedge clock);
  endtask

  // like drain, but gives up after limit cycles
  task automatic wait_results(input int limit);
    int waited;
    waited = 0;
    @(negedge clock);
    dispatch_en = 1'b0;
    preload_en  = 1'b0;
    while (pending_count() != 0 && waited < limit) begin
      @(negedge clock);
      waited++;
    end
  endtask

  task automatic test_single_ops();
    preload_reg(1, 32'h1234_5678);
    preload_reg(2, 32'h0f0f_a5a5);
    for (int k = 0; k <= 4; k++) begin
      dispatch_op(kind_alu, func_t'(k), tag_t'(5 + k), 1, 2);
      drain();
      check_value("alu broadcast cycle", bcast_at[5 + k], accepted_at + 2);
    end
  endtask

  task automatic test_wakeup_chain();
    for (int k = 1; k <= 5; k++) preload_reg(tag_t'(k), next_random());
    dispatch_op(kind_alu, func_add, 10, 1, 2);
    dispatch_op(kind_alu, func_add, 11, 10, 3); // each waits on the previous dest
    dispatch_op(kind_alu, func_add, 12, 11, 4);
    dispatch_op(kind_alu, func_add, 13, 12, 5);
    drain();
    for (int t = 11; t <= 13; t++) begin
      check_value("chain broadcast spacing", bcast_at[t] - bcast_at[t - 1], 1);
    end
  endtask

  task automatic test_multiply();
    for (int k = 1; k <= 3; k++) preload_reg(tag_t'(k), next_random());
    dispatch_op(kind_mult, func_mul, 14, 1, 2);
    drain();
    check_value("mul broadcast cycle", bcast_at[14], accepted_at + 4);
    dispatch_op(kind_mult, func_mul, 15, 1, 3);
    dispatch_op(kind_mult, func_mul, 16, 2, 3); // second one while the first is in flight
    drain();
  endtask

  task automatic test_contention();
    int m_at;
    for (int k = 1; k <= 4; k++) preload_reg(tag_t'(k), next_random());
    model_val[17] = op_result(func_add, model_val[1], model_val[2]);
    pending[17]   = 1'b1;                       // producer comes after its first consumer
    dispatch_op(kind_alu, func_add, 18, 17, 3); // entry 0 waits on 17
    dispatch_op(kind_mult, func_mul, 19, 1, 2);
    m_at = accepted_at;
    dispatch_op(kind_alu, func_add, 17, 1, 2);  // entry 1, on the cdb two cycles later
    dispatch_op(kind_alu, func_xor, 20, 17, 4); // refills entry 1 as 17 issues
    drain();
    // all three done together, then one per cycle
    for (int t = 18; t <= 20; t++) begin
      check_value($sformatf("tag %0d in contention window", t),
                  (bcast_at[t] >= m_at + 4) && (bcast_at[t] <= m_at + 6), 1);
    end
  endtask

  task automatic test_hazard();
    for (int k = 1; k <= 3; k++) preload_reg(tag_t'(k), next_random());
    model_val[21] = op_result(func_mul, model_val[1], model_val[2]);
    pending[21]   = 1'b1;
    dispatch_op(kind_alu, func_sub, 22, 21, 3);
    dispatch_op(kind_alu, func_or, 23, 3, 21);  // waits on src2
    @(negedge clock);
    dispatch_en   = 1'b1;
    dispatch_kind = kind_alu;
    dispatch_func = func_add;
    dest_tag      = 24;                         // a broadcast of 24 would fail the watcher
    src1_tag      = 1;
    src2_tag      = 2;
    src1_ready    = 1'b1;
    src2_ready    = 1'b1;
    #1;
    check_value("rs_hazard", rs_hazard, 1'b1);
    @(negedge clock);
    dispatch_en   = 1'b0;
    dispatch_kind = kind_mult;
    #1;
    check_value("rs_hazard", rs_hazard, 1'b0);  // mult entry still free
    dispatch_op(kind_mult, func_mul, 21, 1, 2);
    drain();
    dispatch_kind = kind_alu;
    #1;
    check_value("rs_hazard", rs_hazard, 1'b0);
  endtask

  task automatic test_random_stream();
    tag_t  dest;
    func_t f;
    for (int k = 0; k < 8; k++) preload_reg(tag_t'(k), next_random());
    for (int n = 0; n < 40; n++) begin
      if (n == 24) drain(); // dest tags wrap, first pass retires before reuse
      dest = tag_t'(8 + n % 24);
      f    = func_t'(pick(6));
      // sources only from preloads and this pass, so no tag is rewritten under a reader
      dispatch_op(f == func_mul ? kind_mult : kind_alu, f, dest,
                  tag_t'(pick(dest)), tag_t'(pick(dest)));
    end
  endtask

  initial begin
    clock         = 1'b0;
    reset         = 1'b1;
    dispatch_en   = 1'b0;
    dispatch_kind = kind_alu;
    dispatch_func = func_add;
    dest_tag      = '0;
    src1_tag      = '0;
    src1_ready    = 1'b0;
    src2_tag      = '0;
    src2_ready    = 1'b0;
    preload_en    = 1'b0;
    preload_tag   = '0;
    preload_value = '0;
    cycle         = 0;
    lcg_state     = 32'h519f;
    for (int t = 0; t < num_tags; t++) begin
      pending[t]  = 1'b0;
      bcast_at[t] = 0;
    end
    repeat (5) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    test_single_ops();
    test_wakeup_chain();
    test_multiply();
    test_contention();
    test_hazard();
    test_random_stream();
    wait_results(settle_limit);
    if (pending_count() != 0) begin
      fail_run("results were still pending at the end of the run");
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

/* src.f */
src/isa_pkg.sv
src/core_pkg.sv
src/reservation_station.sv
src/alu_unit.sv
src/mult_unit.sv
src/cdb_arbiter.sv
src/phys_regfile.sv
src/issue_core.sv
bench/issue_core_tb.sv

/* src/alu_unit.sv */
`timescale 1ns/10ps

module alu_unit
  import isa_pkg::*;
  import core_pkg::*;
(
  input  logic  clock,
  input  logic  reset,
  input  logic  issue_valid,
  input  func_t issue_func,
  input  tag_t  issue_dest,
  input  data_t src1_value,  // operands from the register file
  input  data_t src2_value,
  input  logic  grant,       // cdb taken this cycle
  output logic  fu_hazard,
  output logic  done,        // result waiting for the cdb
  output tag_t  done_tag,
  output data_t done_value
);

  data_t result; // combinational op result

  always_comb begin
    case (issue_func)
      func_add: result = src1_value + src2_value;
      func_sub: result = src1_value - src2_value;
      func_and: result = src1_value & src2_value;
      func_or:  result = src1_value | src2_value;
      func_xor: result = src1_value ^ src2_value;
      default:  result = '0; // mul never routed here
    endcase
  end

  // a granted result frees the unit in the same cycle
  assign fu_hazard = done && !grant;

  always_ff @(posedge clock) begin
    if (reset) begin
      done <= 1'b0;
    end else if (issue_valid) begin
      done <= 1'b1; // new result replaces the one leaving on the cdb
    end else if (grant) begin
      done <= 1'b0;
    end
  end

  // held result
  always_ff @(posedge clock) begin
    if (issue_valid) begin
      done_tag   <= issue_dest;
      done_value <= result;
    end
  end

  // station only sends alu ops to alu entries
  a_no_mul: assert property (@(posedge clock) disable iff (reset)
    issue_valid |-> issue_func != func_mul);

endmodule

/* src/cdb_arbiter.sv */
`timescale 1ns/10ps

module cdb_arbiter
  import core_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  fu_mask_t done,                 // units holding a result
  input  tag_t     done_tag   [num_fu],
  input  data_t    done_value [num_fu],
  output fu_mask_t grant,                // one-hot or zero
  output logic     cdb_valid,
  output tag_t     cdb_tag,
  output data_t    cdb_value
);

  logic [$clog2(num_fu)-1:0] ptr;     // first unit looked at this cycle
  logic [$clog2(num_fu)-1:0] win_idx;

  // search starts at ptr and wraps around
  always_comb begin
    int   idx;
    logic found;
    found   = 1'b0;
    grant   = '0;
    win_idx = '0;
    for (int k = 0; k < num_fu; k++) begin
      idx = int'(ptr) + k;
      if (idx >= num_fu) idx = idx - num_fu;
      if (!found && done[idx]) begin
        found        = 1'b1;
        grant[idx]   = 1'b1;
        win_idx      = idx[$clog2(num_fu)-1:0];
      end
    end
  end

  // bus mux
  assign cdb_valid = |done;
  assign cdb_tag   = done_tag[win_idx];
  assign cdb_value = done_value[win_idx];

  always_ff @(posedge clock) begin
    if (reset) begin
      ptr <= '0;
    end else if (cdb_valid) begin
      ptr <= (win_idx == num_fu - 1) ? '0 : win_idx + 1'b1; // one past the winner
    end
  end

  a_grant: assert property (@(posedge clock) disable iff (reset)
    $onehot0(grant) && ((grant & ~done) == '0));

endmodule

/* src/core_pkg.sv */
package core_pkg;

  import isa_pkg::*; // fu_kind_t for the unit list

  // physical register tags
  localparam int tag_w    = 5;
  localparam int num_tags = 32; // 2**tag_w physical registers

  // datapath
  localparam int data_w = 32;

  // one station entry per unit, so the two counts are the same
  localparam int num_fu = 3;

  // kind of unit behind each entry index
  localparam fu_kind_t fu_list [num_fu] = '{kind_alu, kind_alu, kind_mult};

  // multiplier depth from issue to result
  localparam int mult_stages = 3;

  typedef logic [tag_w-1:0]  tag_t;     // physical register tag
  typedef logic [data_w-1:0] data_t;    // register / result value
  typedef logic [num_fu-1:0] fu_mask_t; // one bit per unit

endpackage

/* src/isa_pkg.sv */
package isa_pkg;

  // function codes carried from dispatch to the units
  typedef enum logic [2:0] {
    func_add = 3'd0, // integer add
    func_sub = 3'd1, // src1 - src2
    func_and = 3'd2,
    func_or  = 3'd3,
    func_xor = 3'd4,
    func_mul = 3'd5  // multiplier only, low half of product
  } func_t;

  // which kind of unit an instruction needs
  typedef enum logic {
    kind_alu  = 1'b0, // single-cycle integer unit
    kind_mult = 1'b1  // pipelined multiplier
  } fu_kind_t;

endpackage

/* src/issue_core.sv */
`timescale 1ns/10ps

module issue_core
  import isa_pkg::*;
  import core_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  logic     dispatch_en,
  input  fu_kind_t dispatch_kind,
  input  func_t    dispatch_func,
  input  tag_t     dest_tag,
  input  tag_t     src1_tag,
  input  logic     src1_ready,
  input  tag_t     src2_tag,
  input  logic     src2_ready,
  input  logic     preload_en,
  input  tag_t     preload_tag,
  input  data_t    preload_value,
  output logic     rs_hazard,
  output logic     cdb_valid,
  output tag_t     cdb_tag,
  output data_t    cdb_value
);

  // station to units
  fu_mask_t issue_valid;
  func_t    issue_func [num_fu];
  tag_t     issue_dest [num_fu];
  tag_t     issue_src1 [num_fu];
  tag_t     issue_src2 [num_fu];
  data_t    src1_value [num_fu]; // operands from the register file
  data_t    src2_value [num_fu];

  // units to arbiter, one driver per bit
  wire fu_mask_t fu_hazard;
  wire fu_mask_t done;
  wire tag_t     done_tag   [num_fu];
  wire data_t    done_value [num_fu];
  fu_mask_t      grant;

  reservation_station rs_inst (
    .clock, .reset, .dispatch_en, .dispatch_kind, .dispatch_func, .dest_tag,
    .src1_tag, .src1_ready, .src2_tag, .src2_ready, .fu_hazard, .cdb_valid,
    .cdb_tag, .rs_hazard, .issue_valid, .issue_func, .issue_dest, .issue_src1,
    .issue_src2
  );

  phys_regfile regfile_inst (
    .clock, .preload_en, .preload_tag, .preload_value, .cdb_valid, .cdb_tag,
    .cdb_value, .read_tag1(issue_src1), .read_tag2(issue_src2),
    .read_value1(src1_value), .read_value2(src2_value)
  );

  // unit kind per index comes from fu_list
  for (genvar i = 0; i < num_fu; i++) begin : g_fu
    if (fu_list[i] == kind_alu) begin : g_alu
      alu_unit alu_inst (
        .clock, .reset, .issue_valid(issue_valid[i]), .issue_func(issue_func[i]),
        .issue_dest(issue_dest[i]), .src1_value(src1_value[i]),
        .src2_value(src2_value[i]), .grant(grant[i]), .fu_hazard(fu_hazard[i]),
        .done(done[i]), .done_tag(done_tag[i]), .done_value(done_value[i])
      );
    end else begin : g_mult
      mult_unit mult_inst (
        .clock, .reset, .issue_valid(issue_valid[i]), .issue_func(issue_func[i]),
        .issue_dest(issue_dest[i]), .src1_value(src1_value[i]),
        .src2_value(src2_value[i]), .grant(grant[i]), .fu_hazard(fu_hazard[i]),
        .done(done[i]), .done_tag(done_tag[i]), .done_value(done_value[i])
      );
    end
  end

  cdb_arbiter arb_inst (
    .clock, .reset, .done, .done_tag, .done_value, .grant, .cdb_valid,
    .cdb_tag, .cdb_value
  );

endmodule

/* src/mult_unit.sv */
`timescale 1ns/10ps

module mult_unit
  import isa_pkg::*;
  import core_pkg::*;
(
  input  logic  clock,
  input  logic  reset,
  input  logic  issue_valid,
  input  func_t issue_func,
  input  tag_t  issue_dest,
  input  data_t src1_value,
  input  data_t src2_value,
  input  logic  grant,
  output logic  fu_hazard,   // pipe frozen
  output logic  done,
  output tag_t  done_tag,
  output data_t done_value
);

  logic [mult_stages-1:0]  stage_valid;
  tag_t                    stage_tag  [mult_stages];
  data_t                   stage_prod [mult_stages]; // partial product, low data_w bits
  data_t                   op_a;                     // multiplicand kept for stage 1
  logic [data_w/2-1:0]     op_b_hi;                  // upper half of multiplier
  logic                    stall;

  // last stage full and not taken by the cdb freezes every stage
  assign stall     = stage_valid[mult_stages-1] && !grant;
  assign fu_hazard = stall;

  always_ff @(posedge clock) begin
    if (reset) begin
      stage_valid <= '0;
    end else if (!stall) begin
      stage_valid <= {stage_valid[mult_stages-2:0], issue_valid};
    end
  end

  always_ff @(posedge clock) begin
    if (!stall) begin
      // stage 0 takes the low half of the multiplier
      stage_tag[0]  <= issue_dest;
      stage_prod[0] <= src1_value * src2_value[data_w/2-1:0];
      op_a          <= src1_value;
      op_b_hi       <= src2_value[data_w-1:data_w/2];
      // stage 1 adds the shifted upper half
      stage_tag[1]  <= stage_tag[0];
      stage_prod[1] <= stage_prod[0] + ((op_a * op_b_hi) << (data_w/2));
      for (int k = 2; k < mult_stages; k++) begin
        stage_tag[k]  <= stage_tag[k-1]; // plain delay to the last stage
        stage_prod[k] <= stage_prod[k-1];
      end
    end
  end

  assign done       = stage_valid[mult_stages-1];
  assign done_tag   = stage_tag[mult_stages-1];
  assign done_value = stage_prod[mult_stages-1];

  // station must honour fu_hazard
  a_no_issue_stalled: assert property (@(posedge clock) disable iff (reset)
    issue_valid |-> !stall);

  a_mul_only: assert property (@(posedge clock) disable iff (reset)
    issue_valid |-> issue_func == func_mul);

endmodule

/* src/phys_regfile.sv */
`timescale 1ns/10ps

module phys_regfile
  import core_pkg::*;
(
  input  logic  clock,
  input  logic  preload_en,              // initial values from outside
  input  tag_t  preload_tag,
  input  data_t preload_value,
  input  logic  cdb_valid,
  input  tag_t  cdb_tag,
  input  data_t cdb_value,
  input  tag_t  read_tag1   [num_fu],    // one read pair per unit
  input  tag_t  read_tag2   [num_fu],
  output data_t read_value1 [num_fu],
  output data_t read_value2 [num_fu]
);

  data_t regs [num_tags];

  always_ff @(posedge clock) begin
    if (preload_en) begin
      regs[preload_tag] <= preload_value;
    end
    if (cdb_valid) begin
      regs[cdb_tag] <= cdb_value; // later assignment, cdb wins on the same tag
    end
  end

  // operand reads see the value being broadcast this cycle
  always_comb begin
    for (int i = 0; i < num_fu; i++) begin
      if (cdb_valid && (cdb_tag == read_tag1[i])) read_value1[i] = cdb_value;
      else                                         read_value1[i] = regs[read_tag1[i]];
      if (cdb_valid && (cdb_tag == read_tag2[i])) read_value2[i] = cdb_value;
      else                                         read_value2[i] = regs[read_tag2[i]];
    end
  end

  // preload happens only while the core is idle
  a_one_writer: assert property (@(posedge clock)
    preload_en |-> !cdb_valid);

endmodule

/* src/reservation_station.sv */
`timescale 1ns/10ps

module reservation_station
  import isa_pkg::*;
  import core_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  logic     dispatch_en,
  input  fu_kind_t dispatch_kind,
  input  func_t    dispatch_func,
  input  tag_t     dest_tag,
  input  tag_t     src1_tag,
  input  logic     src1_ready,
  input  tag_t     src2_tag,
  input  logic     src2_ready,
  input  fu_mask_t fu_hazard,   // unit cannot take an issue this cycle
  input  logic     cdb_valid,
  input  tag_t     cdb_tag,
  output logic     rs_hazard,   // no free entry of the wanted kind
  output fu_mask_t issue_valid,
  output func_t    issue_func [num_fu],
  output tag_t     issue_dest [num_fu],
  output tag_t     issue_src1 [num_fu],
  output tag_t     issue_src2 [num_fu]
);

  // entry state
  fu_mask_t busy;                // entry holds an instruction
  func_t    ent_func [num_fu];
  tag_t     ent_dest [num_fu];
  tag_t     ent_src1 [num_fu];
  tag_t     ent_src2 [num_fu];
  fu_mask_t ent_rdy1;            // stored ready bits
  fu_mask_t ent_rdy2;

  // per-cycle decisions
  fu_mask_t src1_hit;            // cdb broadcasts this entry's src1
  fu_mask_t src2_hit;
  fu_mask_t issue_now;
  fu_mask_t entry_free;          // idle, or leaving this cycle
  fu_mask_t entry_match;         // free and of the dispatched kind
  fu_mask_t fill;                // one-hot, entry taking the dispatch
  logic     in_hit1;             // dispatched source on the cdb right now
  logic     in_hit2;

  // wakeup and issue select
  always_comb begin
    for (int i = 0; i < num_fu; i++) begin
      src1_hit[i]    = cdb_valid && (cdb_tag == ent_src1[i]);
      src2_hit[i]    = cdb_valid && (cdb_tag == ent_src2[i]);
      issue_now[i]   = busy[i] && (ent_rdy1[i] || src1_hit[i]) &&
                       (ent_rdy2[i] || src2_hit[i]) && !fu_hazard[i];
      entry_free[i]  = !busy[i] || issue_now[i];
      entry_match[i] = entry_free[i] && (fu_list[i] == dispatch_kind);
    end
  end

  assign rs_hazard = (entry_match == '0); // level, independent of dispatch_en

  // lowest matching entry wins the dispatch
  always_comb begin
    logic found;
    found = 1'b0;
    fill  = '0;
    if (dispatch_en) begin
      for (int i = 0; i < num_fu; i++) begin
        if (entry_match[i] && !found) begin
          fill[i] = 1'b1;
          found   = 1'b1;
        end
      end
    end
  end

  // a source being broadcast as it arrives is already ready
  assign in_hit1 = cdb_valid && (cdb_tag == src1_tag);
  assign in_hit2 = cdb_valid && (cdb_tag == src2_tag);

  // issue bundle per unit
  always_comb begin
    for (int i = 0; i < num_fu; i++) begin
      issue_func[i] = ent_func[i];
      issue_dest[i] = ent_dest[i];
      issue_src1[i] = ent_src1[i]; // register file reads these tags
      issue_src2[i] = ent_src2[i];
    end
  end
  assign issue_valid = issue_now;

  // busy bits
  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= '0;
    end else begin
      busy <= (busy & ~issue_now) | fill; // issue clears, dispatch refills
    end
  end

  // entry payload and ready bits
  always_ff @(posedge clock) begin
    for (int i = 0; i < num_fu; i++) begin
      if (fill[i]) begin
        ent_func[i] <= dispatch_func;
        ent_dest[i] <= dest_tag;
        ent_src1[i] <= src1_tag;
        ent_src2[i] <= src2_tag;
        ent_rdy1[i] <= src1_ready || in_hit1;
        ent_rdy2[i] <= src2_ready || in_hit2;
      end else begin
        if (src1_hit[i]) ent_rdy1[i] <= 1'b1; // wakeup
        if (src2_hit[i]) ent_rdy2[i] <= 1'b1;
      end
    end
  end

  for (genvar i = 0; i < num_fu; i++) begin : g_chk
    a_issue_busy: assert property (@(posedge clock) disable iff (reset)
      issue_valid[i] |-> busy[i]);
  end

  // a dropped dispatch leaves no newly busy entry behind
  a_drop: assert property (@(posedge clock) disable iff (reset)
    dispatch_en && rs_hazard |=> busy == $past(busy & ~issue_valid));

endmodule
